/* hw/rv_pkg.sv */
// ----------------------------------------------------------------------
// rv_pkg: widths, opcode and ALU encodings and the pipeline stage items
// shared by the three-stage RV64I integer core
// ----------------------------------------------------------------------
package rv_pkg;

  // datapath widths
  localparam int XLEN    = 64;
  localparam int INSTR_W = 32;
  localparam int REG_AW  = 5;
  localparam int CNT_W   = 32;

  // major opcodes kept by the core, anything else is illegal
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111
  } opcode_e;

  // alu operation selector
  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_and      = 4'd2,
    alu_or       = 4'd3,
    alu_xor      = 4'd4,
    alu_sll      = 4'd5,
    alu_srl      = 4'd6,
    alu_slt      = 4'd7,
    alu_pass_imm = 4'd8
  } alu_op_e;

  // decode to execute item
  typedef struct packed {
    logic              valid;
    logic              wr_en;    // low for rd x0
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;      // sign extended
    logic              use_imm;
  } id_ex_t;

  // execution result, also the commit and register write item
  typedef struct packed {
    logic              valid;
    logic              wr_en;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
  } ex_wb_t;

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// integer register file: 32 x 64 bit, two read ports, one write port
// ----------------------------------------------------------------------
module reg_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [rv_pkg::REG_AW-1:0] i_rs1_addr,
  input  logic [rv_pkg::REG_AW-1:0] i_rs2_addr,
  output logic [rv_pkg::XLEN-1:0]   o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]   o_rs2_data,
  input  rv_pkg::ex_wb_t            i_wr
);
  import rv_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.valid && i_wr.wr_en) begin
      regs[i_wr.rd] <= i_wr.data;
    end
  end

  // reads are not bypassed, a same-edge write is covered by forwarding
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// decode stage: decodes the RV64I subset, reads the register file and
// registers the decode to execute item
// ----------------------------------------------------------------------
module decode_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_instr_valid,
  input  logic [rv_pkg::INSTR_W-1:0] i_instr,
  output logic [rv_pkg::REG_AW-1:0]  o_rs1_addr,
  output logic [rv_pkg::REG_AW-1:0]  o_rs2_addr,
  input  logic [rv_pkg::XLEN-1:0]    i_rs1_data,
  input  logic [rv_pkg::XLEN-1:0]    i_rs2_data,
  output rv_pkg::id_ex_t             o_id_ex
);
  import rv_pkg::*;

  opcode_e           opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rd;
  logic              legal;
  alu_op_e           alu_op;
  logic [XLEN-1:0]   imm;
  logic              use_imm;
  id_ex_t            id_ex_d;

  assign opcode     = opcode_e'(i_instr[6:0]);
  assign funct3     = i_instr[14:12];
  assign funct7     = i_instr[31:25];
  assign rd         = i_instr[11:7];
  assign o_rs1_addr = i_instr[19:15];
  assign o_rs2_addr = i_instr[24:20];

  always_comb begin
    legal   = 1'b0;
    alu_op  = alu_add;
    use_imm = 1'b0;
    // i-type by default
    imm     = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
    case (opcode)
      opc_op: begin
        if (funct7 == 7'b0000000) begin
          legal = 1'b1;
          case (funct3)
            3'b000:  alu_op = alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = alu_srl;
            3'b110:  alu_op = alu_or;
            3'b111:  alu_op = alu_and;
            default: legal  = 1'b0;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          legal  = 1'b1;
          alu_op = alu_sub;
        end
      end
      opc_op_imm: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          3'b000:  alu_op = alu_add;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          // immediate shifts and sltiu not supported
          default: legal  = 1'b0;
        endcase
      end
      opc_lui: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        alu_op  = alu_pass_imm;
        imm     = {{(XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    id_ex_d.valid    = i_instr_valid & legal;
    // x0 writes retire but never reach the register file
    id_ex_d.wr_en    = i_instr_valid & legal & (rd != '0);
    id_ex_d.alu_op   = alu_op;
    id_ex_d.rd       = rd;
    id_ex_d.rs1      = o_rs1_addr;
    id_ex_d.rs2      = o_rs2_addr;
    id_ex_d.rs1_data = i_rs1_data;
    id_ex_d.rs2_data = i_rs2_data;
    id_ex_d.imm      = imm;
    id_ex_d.use_imm  = use_imm;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_id_ex <= '0;
    end else begin
      o_id_ex <= id_ex_d;
    end
  end

  a_valid_op_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    o_id_ex.valid |-> !$isunknown(o_id_ex.alu_op) &&
                      (o_id_ex.alu_op inside {[alu_add:alu_pass_imm]})
  );

endmodule

/* hw/exec_stage.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// execute stage: operand forwarding, ALU and the execute result register
// ----------------------------------------------------------------------
module exec_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  rv_pkg::id_ex_t i_id_ex,
  input  rv_pkg::ex_wb_t i_commit,
  output rv_pkg::ex_wb_t o_ex_wb
);
  import rv_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic [5:0]      shamt;
  logic [XLEN-1:0] alu_result;
  ex_wb_t          ex_wb_d;

  // youngest producer wins, then the value read at decode
  function automatic logic [XLEN-1:0] pick_operand(
    input logic [REG_AW-1:0] src,
    input logic [XLEN-1:0]   reg_data,
    input ex_wb_t            younger,
    input ex_wb_t            older
  );
    if (younger.valid && younger.wr_en && younger.rd == src) begin
      return younger.data;
    end
    if (older.valid && older.wr_en && older.rd == src) begin
      return older.data;
    end
    return reg_data;
  endfunction

  assign op_a    = pick_operand(i_id_ex.rs1, i_id_ex.rs1_data, o_ex_wb, i_commit);
  assign rs2_val = pick_operand(i_id_ex.rs2, i_id_ex.rs2_data, o_ex_wb, i_commit);
  assign op_b    = i_id_ex.use_imm ? i_id_ex.imm : rs2_val;
  assign shamt   = op_b[5:0];

  always_comb begin
    case (i_id_ex.alu_op)
      alu_add:      alu_result = op_a + op_b;
      alu_sub:      alu_result = op_a - op_b;
      alu_and:      alu_result = op_a & op_b;
      alu_or:       alu_result = op_a | op_b;
      alu_xor:      alu_result = op_a ^ op_b;
      alu_sll:      alu_result = op_a << shamt;
      alu_srl:      alu_result = op_a >> shamt;
      alu_slt:      alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_pass_imm: alu_result = i_id_ex.imm;
      default:      alu_result = '0;
    endcase
  end

  always_comb begin
    ex_wb_d.valid = i_id_ex.valid;
    ex_wb_d.wr_en = i_id_ex.wr_en;
    ex_wb_d.rd    = i_id_ex.rd;
    ex_wb_d.data  = alu_result;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ex_wb <= '0;
    end else begin
      o_ex_wb <= ex_wb_d;
    end
  end

  // decode owns the x0 filter, forwarding relies on it
  a_wr_en_rd_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
    o_ex_wb.wr_en |-> o_ex_wb.rd != '0
  );

endmodule

/* hw/retire_stage.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// retire stage: commit register and retired-instruction counter
// ----------------------------------------------------------------------
module retire_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rv_pkg::ex_wb_t            i_ex_wb,
  output rv_pkg::ex_wb_t            o_commit,
  output logic                      o_wb_valid,
  output logic [rv_pkg::REG_AW-1:0] o_wb_rd,
  output logic [rv_pkg::XLEN-1:0]   o_wb_data,
  output logic [rv_pkg::CNT_W-1:0]  o_retire_count
);
  import rv_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_commit       <= '0;
      o_retire_count <= '0;
    end else begin
      o_commit <= i_ex_wb;
      // x0 writes still count as retired
      if (i_ex_wb.valid) begin
        o_retire_count <= o_retire_count + CNT_W'(1);
      end
    end
  end

  assign o_wb_valid = o_commit.valid & o_commit.wr_en;
  assign o_wb_rd    = o_commit.rd;
  assign o_wb_data  = o_commit.data;

  a_count_follows_valid : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$past(i_ex_wb.valid) |-> $stable(o_retire_count)
  );

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// three-stage RV64I integer core, fixed two cycle commit latency
// ----------------------------------------------------------------------
module rv_core_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_instr_valid,
  input  logic [rv_pkg::INSTR_W-1:0] i_instr,
  output logic                       o_wb_valid,
  output logic [rv_pkg::REG_AW-1:0]  o_wb_rd,
  output logic [rv_pkg::XLEN-1:0]    o_wb_data,
  output logic [rv_pkg::CNT_W-1:0]   o_retire_count
);
  import rv_pkg::*;

  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  id_ex_t            id_ex;
  ex_wb_t            ex_wb;
  ex_wb_t            commit;

  decode_stage u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_rs1_addr    (rs1_addr),
    .o_rs2_addr    (rs2_addr),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .o_id_ex       (id_ex)
  );

  // written from the execute register, same edge as the commit register
  reg_file u_reg_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr       (ex_wb)
  );

  exec_stage u_exec (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_id_ex  (id_ex),
    .i_commit (commit),
    .o_ex_wb  (ex_wb)
  );

  retire_stage u_retire (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_ex_wb        (ex_wb),
    .o_commit       (commit),
    .o_wb_valid     (o_wb_valid),
    .o_wb_rd        (o_wb_rd),
    .o_wb_data      (o_wb_data),
    .o_retire_count (o_retire_count)
  );

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// testbench clock source, 100 ns period
// ----------------------------------------------------------------------
module clk_gen (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    // half period
    forever #50 o_clk = ~o_clk;
  end

endmodule

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// testbench for the three-stage core that replays the instruction
// stream from the data file with random idle gaps and checks commits
// ----------------------------------------------------------------------
module tb_rv_core;
  import rv_pkg::*;

  localparam int MAX_WORDS = 256;

  // one outstanding commit and the cycle count at which it must show
  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
    logic [31:0]       cycle;
  } commit_exp_t;

  logic                clk;
  logic                rst_n;
  logic                i_instr_valid;
  logic [INSTR_W-1:0]  i_instr;
  logic                o_wb_valid;
  logic [REG_AW-1:0]   o_wb_rd;
  logic [XLEN-1:0]     o_wb_data;
  logic [CNT_W-1:0]    o_retire_count;

  // four words per entry for kind, instruction, rd and value
  logic [63:0]         stim [0:MAX_WORDS-1];
  commit_exp_t         exp_q [$];
  int                  n_entries = 0;
  int                  n_retire = 0;
  logic [31:0]         cycle_count = '0;
  logic [31:0]         lfsr;

  clk_gen u_clk_gen (
    .o_clk (clk)
  );

  rv_core_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_instr_valid  (i_instr_valid),
    .i_instr        (i_instr),
    .o_wb_valid     (o_wb_valid),
    .o_wb_rd        (o_wb_rd),
    .o_wb_data      (o_wb_data),
    .o_retire_count (o_retire_count)
  );

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  // number of rising edges seen so far
  always @(posedge clk) begin
    cycle_count <= cycle_count + 32'd1;
  end

  always @(negedge clk) begin
    if (n_entries > 0 && cycle_count > 32'(n_entries * 4 + 20)) begin
      abort_run($sformatf("timeout after %0d cycles, stream did not finish", cycle_count));
    end
  end

  // outputs only move on rising edges so sample in the low phase
  always @(negedge clk) begin
    commit_exp_t head;
    if (rst_n && o_wb_valid) begin
      assert (exp_q.size() != 0)
        else abort_run("a commit appeared with no committing instruction outstanding");
      head = exp_q.pop_front();
      assert (o_wb_rd == head.rd)
        else abort_run($sformatf("ERR o_wb_rd got %h expected %h", o_wb_rd, head.rd));
      assert (o_wb_data == head.data)
        else abort_run($sformatf("ERR o_wb_data got %h expected %h", o_wb_data, head.data));
      assert (cycle_count == head.cycle)
        else abort_run($sformatf("commit to x%0d came at cycle %0d instead of cycle %0d",
                                 head.rd, cycle_count, head.cycle));
    end
  end

  initial begin
    logic [1:0]  gap;
    logic [63:0] kind;
    rst_n         = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    lfsr          = 32'hbc43;
    for (int a = 0; a < MAX_WORDS; a++) begin
      stim[a] = {~32'(a), 32'(a)};
    end
    $readmemh("bench/alu_input.hex", stim);

    // kinds above 2 end the stream
    while (4 * n_entries + 3 < MAX_WORDS && stim[4 * n_entries] < 64'd3) begin
      if (stim[4 * n_entries] != 64'd2) begin
        n_retire++;
      end
      n_entries++;
    end
    assert (n_entries > 0)
      else abort_run("no instruction entries were found in bench/alu_input.hex");

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (o_wb_valid == 1'b0)
      else abort_run($sformatf("ERR o_wb_valid got %h expected 0", o_wb_valid));
    assert (o_retire_count == '0)
      else abort_run($sformatf("ERR o_retire_count got %h expected 0", o_retire_count));
    assert (o_wb_rd == '0)
      else abort_run($sformatf("ERR o_wb_rd got %h expected 0", o_wb_rd));
    assert (o_wb_data == '0)
      else abort_run($sformatf("ERR o_wb_data got %h expected 0", o_wb_data));

    for (int e = 0; e < n_entries; e++) begin
      kind          = stim[4 * e];
      i_instr_valid = 1'b1;
      i_instr       = stim[4 * e + 1][INSTR_W-1:0];
      // accepted at the next edge and visible two edges later
      if (kind == 64'd0) begin
        exp_q.push_back('{rd: stim[4 * e + 2][REG_AW-1:0], data: stim[4 * e + 3],
                          cycle: cycle_count + 32'd3});
      end
      @(negedge clk);
      gap = '0;
      repeat (2) begin
        gap  = {gap[0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
      end
      // instruction word is left in place while idle
      i_instr_valid = 1'b0;
      repeat (gap) @(negedge clk);
    end
    i_instr_valid = 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // two cycle latency covers a trailing rd x0 entry
    repeat (2) @(negedge clk);
    assert (o_retire_count == CNT_W'(n_retire))
      else abort_run($sformatf("ERR o_retire_count got %h expected %h",
                               o_retire_count, CNT_W'(n_retire)));

    $display("All checks passed");
    $finish;
  end

endmodule

/* bench/alu_input.hex */
// kind (0 commits, 1 retires without write, 2 illegal, f end of stream)
// columns: kind  instruction  expected rd  expected 64-bit value
0 00500093 01 0000000000000005
0 ffd00113 02 fffffffffffffffd
0 123451b7 03 0000000012345000
0 80000237 04 ffffffff80000000
0 0f006293 05 00000000000000f0
0 fff04313 06 ffffffffffffffff
0 002083b3 07 0000000000000002
0 40138433 08 fffffffffffffffd
0 007424b3 09 0000000000000001
0 00549533 0a 0001000000000000
0 007255b3 0b 3fffffffe0000000
0 0065f633 0c 3fffffffe0000000
0 00a646b3 0d 3ffeffffe0000000
0 00d1e733 0e 3ffefffff2345000
1 00708013 00 0000000000000000
0 001007b3 0f 0000000000000005
2 0000b083 00 0000000000000000
2 ffffffff 00 0000000000000000
0 0020a833 10 0000000000000000
0 5a537893 11 00000000000005a5
0 fff88913 12 00000000000005a4
0 411909b3 13 ffffffffffffffff
1 01398033 00 0000000000000000
0 00009a33 14 0000000000000005
0 0099dab3 15 7fffffffffffffff
0 00322b33 16 0000000000000001
f 00000000 00 0000000000000000

/* filelist.f */
hw/rv_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/retire_stage.sv
hw/rv_core_top.sv
bench/clk_gen.sv
bench/tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
